// ==== common/lsu_defines.svh ====
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

////////////////////////////////////////
// Data path
////////////////////////////////////////
`define LSU_DATA_W 32		// Word width
`define LSU_BYTES 4			// Byte lanes per word

////////////////////////////////////////
// Address space
////////////////////////////////////////
`define LSU_ADDR_W 12		// Core byte address
`define LSU_WADDR_W 10		// Word address into the memory
`define LSU_MEM_WORDS 1024	// Memory depth in words

`endif

// ==== common/lsu_pkg.sv ====
`default_nettype none

`include "lsu_defines.svh"

package lsu_pkg;

	// Access size, same codes as RISC-V funct3
	typedef enum logic [2:0] {
		MEM_B  = 3'b000,	// Signed byte
		MEM_H  = 3'b001,	// Signed halfword
		MEM_W  = 3'b010,	// Full word
		MEM_BU = 3'b100,	// Unsigned byte, loads only
		MEM_HU = 3'b101		// Unsigned halfword, loads only
	} mem_op_e;

	// One data word, split into byte lanes or halfword lanes
	// Store side places data through it, load side picks data from it
	typedef union packed {
		logic [`LSU_BYTES-1:0][7:0] bytes;		// Lane 0 is the low byte
		logic [`LSU_BYTES/2-1:0][15:0] halves;	// Lane 0 is the low half
	} lane_word_u;

endpackage

`default_nettype wire

// ==== common/lsu_req_if.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "lsu_defines.svh"

// Aligned request, EXE/MEM register to data memory
interface lsu_req_if;
	logic valid;						// Request present this cycle
	logic we;							// Store
	logic [`LSU_BYTES-1:0] be;			// Byte enables, zero for loads
	logic [`LSU_WADDR_W-1:0] word_addr;
	logic [`LSU_DATA_W-1:0] wdata;		// Store data already in its lanes
	lsu_pkg::mem_op_e op;				// Carried on for the load side
	logic [1:0] byte_offset;			// Low address bits

	modport stage (output valid, we, be, word_addr, wdata, op, byte_offset);
	modport mem (input valid, we, be, word_addr, wdata, op, byte_offset);
endinterface

`default_nettype wire

// ==== common/lsu_rsp_if.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "lsu_defines.svh"

// Raw read word plus load attributes, memory to MEM/WB stage
interface lsu_rsp_if;
	logic valid;					// Load data present
	logic [`LSU_DATA_W-1:0] rdata;	// Whole word, not yet extracted
	lsu_pkg::mem_op_e op;
	logic [1:0] byte_offset;

	modport mem (output valid, rdata, op, byte_offset);
	modport stage (input valid, rdata, op, byte_offset);
endinterface

`default_nettype wire

// ==== verilog/store_align.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "lsu_defines.svh"

module store_align (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic req_valid,
	input wire logic req_we,
	input wire lsu_pkg::mem_op_e req_op,
	input wire logic [`LSU_ADDR_W-1:0] req_addr,
	input wire logic [`LSU_DATA_W-1:0] req_wdata,	// Store data in low bits
	lsu_req_if.stage req
);

	logic [1:0] offset;
	lsu_pkg::lane_word_u lane;		// Store data moved into its lane
	logic [`LSU_BYTES-1:0] be;

	assign offset = req_addr[1:0];

	////////////////////////////////////////
	// Lane placement and byte enables
	////////////////////////////////////////
	always_comb begin
		lane = '0;
		be = '0;
		case (req_op)
			lsu_pkg::MEM_B, lsu_pkg::MEM_BU: begin
				lane.bytes[offset] = req_wdata[7:0];
				be[offset] = 1'b1;
			end
			lsu_pkg::MEM_H, lsu_pkg::MEM_HU: begin
				// Bit 0 of the address is ignored here
				lane.halves[offset[1]] = req_wdata[15:0];
				be = offset[1] ? 4'b1100 : 4'b0011;
			end
			default: begin
				lane = req_wdata;	// Word, both low bits ignored
				be = '1;
			end
		endcase
	end

	////////////////////////////////////////
	// EXE/MEM register
	////////////////////////////////////////
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			req.valid <= 1'b0;
			req.we <= 1'b0;
		end else begin
			req.valid <= req_valid;
			req.we <= req_valid & req_we;	// Never a store without valid
		end
	end

	always_ff @(posedge clk) begin
		if (req_valid) begin
			req.be <= req_we ? be : '0;		// Loads write nothing
			req.word_addr <= req_addr[`LSU_ADDR_W-1:`LSU_ADDR_W-`LSU_WADDR_W];
			req.wdata <= lane;
			req.op <= req_op;
			req.byte_offset <= offset;
		end
	end

	// Undefined funct3 would corrupt lanes two stages later
	op_defined: assert property (@(posedge clk) disable iff (!rst_n)
		req_valid |-> req_op inside {lsu_pkg::MEM_B, lsu_pkg::MEM_H, lsu_pkg::MEM_W,
			lsu_pkg::MEM_BU, lsu_pkg::MEM_HU});

endmodule

`default_nettype wire

// ==== datamem/data_mem.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "lsu_defines.svh"

module data_mem (
	input wire logic clk,
	input wire logic rst_n,
	lsu_req_if.mem req,		// Core side from EXE/MEM
	lsu_rsp_if.mem rsp,		// Core side to load stage

	// Wishbone classic slave
	input wire logic wb_cyc,
	input wire logic wb_stb,
	input wire logic wb_we,
	input wire logic [3:0] wb_sel,
	input wire logic [`LSU_WADDR_W-1:0] wb_adr,		// Word address
	input wire logic [`LSU_DATA_W-1:0] wb_dat_i,
	output logic [`LSU_DATA_W-1:0] wb_dat_o,		// Valid while ack high
	output logic wb_ack
);

	logic [`LSU_DATA_W-1:0] mem [`LSU_MEM_WORDS];
	logic wb_go;		// Strobe seen and not yet acked
	logic core_wr;
	logic core_rd;

	assign wb_go = wb_cyc & wb_stb & ~wb_ack;
	assign core_wr = req.valid & req.we;
	assign core_rd = req.valid & ~req.we;

	////////////////////////////////////////
	// Byte-enabled writes, both ports
	////////////////////////////////////////
	always_ff @(posedge clk) begin
		for (int i = 0; i < `LSU_BYTES; i++) begin
			if (wb_go && wb_we && wb_sel[i])
				mem[wb_adr][i*8 +: 8] <= wb_dat_i[i*8 +: 8];
			// Core comes last so it wins a shared byte
			if (core_wr && req.be[i])
				mem[req.word_addr][i*8 +: 8] <= req.wdata[i*8 +: 8];
		end
	end

	////////////////////////////////////////
	// Reads and ack
	////////////////////////////////////////
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rsp.valid <= 1'b0;
			wb_ack <= 1'b0;
		end else begin
			rsp.valid <= core_rd;
			wb_ack <= wb_go;	// High one cycle then low at least one
		end
	end

	// Old word on a same-edge read and write
	always_ff @(posedge clk) begin
		if (core_rd) begin
			rsp.rdata <= mem[req.word_addr];
			rsp.op <= req.op;
			rsp.byte_offset <= req.byte_offset;
		end
		if (wb_go)
			wb_dat_o <= mem[wb_adr];	// Also loaded on writes where the master ignores it
	end

	// Master holds the strobe through the ack cycle
	ack_with_stb: assert property (@(posedge clk) disable iff (!rst_n)
		wb_ack |-> wb_cyc && wb_stb);

	// Ack and read data belong to the request still on the bus
	ack_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
		wb_ack |-> $stable(wb_adr) && $stable(wb_we) && $stable(wb_sel));

endmodule

`default_nettype wire

// ==== verilog/load_extract.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "lsu_defines.svh"

module load_extract (
	input wire logic clk,
	input wire logic rst_n,
	lsu_rsp_if.stage rsp,
	output logic load_valid,
	output logic [`LSU_DATA_W-1:0] load_data
);

	lsu_pkg::lane_word_u lane;
	logic [7:0] sel_b;					// Byte picked by offset
	logic [15:0] sel_h;					// Half picked by offset bit 1
	logic [`LSU_DATA_W-1:0] ext;		// Extended result

	assign lane = rsp.rdata;
	assign sel_b = lane.bytes[rsp.byte_offset];
	assign sel_h = lane.halves[rsp.byte_offset[1]];

	////////////////////////////////////////
	// Sign or zero extension
	////////////////////////////////////////
	always_comb begin
		case (rsp.op)
			lsu_pkg::MEM_B:  ext = {{(`LSU_DATA_W-8){sel_b[7]}}, sel_b};
			lsu_pkg::MEM_BU: ext = {{(`LSU_DATA_W-8){1'b0}}, sel_b};
			lsu_pkg::MEM_H:  ext = {{(`LSU_DATA_W-16){sel_h[15]}}, sel_h};
			lsu_pkg::MEM_HU: ext = {{(`LSU_DATA_W-16){1'b0}}, sel_h};
			default:         ext = lane;	// Whole word
		endcase
	end

	// MEM/WB register
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			load_valid <= 1'b0;
		else
			load_valid <= rsp.valid;
	end

	always_ff @(posedge clk) begin
		if (rsp.valid)
			load_data <= ext;
	end

	// Op travels two registers from the core port and must still decode
	rsp_op_defined: assert property (@(posedge clk) disable iff (!rst_n)
		rsp.valid |-> rsp.op inside {lsu_pkg::MEM_B, lsu_pkg::MEM_H, lsu_pkg::MEM_W,
			lsu_pkg::MEM_BU, lsu_pkg::MEM_HU});

endmodule

`default_nettype wire

// ==== verilog/mem_stage_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "lsu_defines.svh"

module mem_stage_top (
	input wire logic CLK,
	input wire logic rst_n,

	// Core request, one per cycle, no back-pressure
	input wire logic req_valid,
	input wire logic req_we,
	input wire lsu_pkg::mem_op_e req_op,
	input wire logic [`LSU_ADDR_W-1:0] req_addr,
	input wire logic [`LSU_DATA_W-1:0] req_wdata,

	// Load result, two cycles after the request
	output logic load_valid,
	output logic [`LSU_DATA_W-1:0] load_data,

	// Wishbone classic slave
	input wire logic wb_cyc,
	input wire logic wb_stb,
	input wire logic wb_we,
	input wire logic [3:0] wb_sel,
	input wire logic [`LSU_WADDR_W-1:0] wb_adr,
	input wire logic [`LSU_DATA_W-1:0] wb_dat_i,
	output logic [`LSU_DATA_W-1:0] wb_dat_o,
	output logic wb_ack
);

	lsu_req_if req_bus ();		// EXE/MEM register outputs
	lsu_rsp_if rsp_bus ();		// Memory read outputs

	////////////////////////////////////////
	// Pipeline stages
	////////////////////////////////////////
	store_align store_i (
		.clk(CLK),
		.rst_n(rst_n),
		.req_valid(req_valid),
		.req_we(req_we),
		.req_op(req_op),
		.req_addr(req_addr),
		.req_wdata(req_wdata),
		.req(req_bus.stage)
	);

	data_mem mem_i (
		.clk(CLK),
		.rst_n(rst_n),
		.req(req_bus.mem),
		.rsp(rsp_bus.mem),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_sel(wb_sel),
		.wb_adr(wb_adr),
		.wb_dat_i(wb_dat_i),
		.wb_dat_o(wb_dat_o),
		.wb_ack(wb_ack)
	);

	load_extract load_i (
		.clk(CLK),
		.rst_n(rst_n),
		.rsp(rsp_bus.stage),
		.load_valid(load_valid),
		.load_data(load_data)
	);

endmodule

`default_nettype wire

// ==== bench/tb_mem_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "lsu_defines.svh"

module tb_mem_stage;

	localparam int N_FILL = `LSU_MEM_WORDS;	// One word store per address
	localparam int N_RT = 200;				// Full-range word loads
	localparam int N_SUB = 300;				// Store then load pairs
	localparam int N_B2B = 400;
	localparam int N_WB = 100;				// Bus access plus core access
	localparam int WIN = 16;				// Small window, lots of address hits
	localparam int LIMIT = (N_FILL + N_RT + 2 * N_SUB + N_B2B + 2 * N_WB) * 4 + 100;

	logic CLK;
	logic rst_n;
	logic req_valid;
	logic req_we;
	lsu_pkg::mem_op_e req_op;
	logic [`LSU_ADDR_W-1:0] req_addr;
	logic [`LSU_DATA_W-1:0] req_wdata;
	logic load_valid;
	logic [`LSU_DATA_W-1:0] load_data;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [3:0] wb_sel;
	logic [`LSU_WADDR_W-1:0] wb_adr;
	logic [`LSU_DATA_W-1:0] wb_dat_i;
	logic [`LSU_DATA_W-1:0] wb_dat_o;
	logic wb_ack;

	////////////////////////////////////////
	// Reference model state
	////////////////////////////////////////
	logic [`LSU_DATA_W-1:0] model_mem [`LSU_MEM_WORDS];
	int due_q[$];							// Cycle a load result shows up
	logic [`LSU_DATA_W-1:0] data_q[$];
	logic p_valid;							// Request sampled at the last edge
	logic p_we;
	lsu_pkg::mem_op_e p_op;
	logic [`LSU_ADDR_W-1:0] p_addr;
	logic [`LSU_DATA_W-1:0] p_wdata;
	logic ack_exp;							// Ack due at this edge
	logic ack_we;
	logic [`LSU_DATA_W-1:0] ack_dat;
	int cycle_n = 0;
	string test_name = "reset";

	mem_stage_top dut_i (.*);

	initial begin
		CLK = 1'b0;
		forever #20 CLK = ~CLK;
	end

	task automatic stop_with_error(input string what);
		$display("%s", what);
		$display("Done: errors found");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act)
			stop_with_error($sformatf("Mismatch %s expected %h actual %h", name, exp, act));
	endtask

	// Lane pick and extension, straight from the RISC-V load rules
	function automatic logic [31:0] extract_load(input logic [31:0] w,
			input lsu_pkg::mem_op_e op, input logic [1:0] off);
		logic [7:0] b;
		logic [15:0] h;
		b = w[{off, 3'b000} +: 8];
		h = w[{off[1], 4'b0000} +: 16];		// Bit 0 ignored
		case (op)
			lsu_pkg::MEM_B:  return {{24{b[7]}}, b};
			lsu_pkg::MEM_BU: return {24'd0, b};
			lsu_pkg::MEM_H:  return {{16{h[15]}}, h};
			lsu_pkg::MEM_HU: return {16'd0, h};
			default:         return w;
		endcase
	endfunction

	function automatic logic [31:0] merge_store(input logic [31:0] old,
			input lsu_pkg::mem_op_e op, input logic [1:0] off, input logic [31:0] d);
		logic [31:0] r;
		r = old;
		case (op)
			lsu_pkg::MEM_B: r[{off, 3'b000} +: 8] = d[7:0];
			lsu_pkg::MEM_H: r[{off[1], 4'b0000} +: 16] = d[15:0];
			default:        r = d;
		endcase
		return r;
	endfunction

	function automatic lsu_pkg::mem_op_e rand_op(input logic store);
		int unsigned r;
		r = store ? $urandom_range(2, 0) : $urandom_range(4, 0);	// Stores: B, H, W
		case (r)
			0:       return lsu_pkg::MEM_B;
			1:       return lsu_pkg::MEM_H;
			2:       return lsu_pkg::MEM_W;
			3:       return lsu_pkg::MEM_BU;
			default: return lsu_pkg::MEM_HU;
		endcase
	endfunction

	function automatic logic [11:0] rand_addr(input int words);
		return 12'($urandom_range(words * 4 - 1, 0));
	endfunction

	// Core port drive, caller sits on a rising edge
	task automatic set_core(input logic v, input logic we, input lsu_pkg::mem_op_e op,
			input logic [11:0] addr, input logic [31:0] d);
		req_valid <= v;
		req_we <= we;
		req_op <= op;
		req_addr <= addr;
		req_wdata <= d;
	endtask

	task automatic random_core(input int words);
		logic [31:0] r;
		logic we;
		r = $urandom;
		we = r[0];
		set_core(r[1] | r[2], we, rand_op(we), rand_addr(words), $urandom);	// 3/4 busy
	endtask

	task automatic start_test(input string name);
		@(negedge CLK);
		test_name = name;
	endtask

	// Classic cycle, stb held until ack, core traffic alongside
	task automatic wb_access(input logic we, input logic [9:0] adr, input logic [3:0] sel,
			input logic [31:0] dat);
		@(posedge CLK);
		wb_cyc <= 1'b1;
		wb_stb <= 1'b1;
		wb_we <= we;
		wb_sel <= sel;
		wb_adr <= adr;
		wb_dat_i <= dat;
		random_core(WIN);
		do begin
			@(posedge CLK);
			random_core(WIN);
		end while (!wb_ack);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
	endtask

	////////////////////////////////////////
	// Model and response checks
	////////////////////////////////////////
	always @(posedge CLK) begin : model
		logic wb_now;
		if (!rst_n) begin
			p_valid = 1'b0;
			ack_exp = 1'b0;
			due_q.delete();
			data_q.delete();
		end else begin
			if (ack_exp) begin
				check_value({test_name, " wb_ack"}, 32'd1, 32'(wb_ack));
				if (!ack_we)
					check_value({test_name, " wb_dat_o"}, ack_dat, wb_dat_o);
			end else if (wb_ack) begin
				stop_with_error({"wb_ack high with no strobe to answer in ", test_name});
			end
			if (due_q.size() > 0 && due_q[0] == cycle_n) begin
				if (!load_valid)
					stop_with_error({"load_valid missing two cycles after a load in ", test_name});
				check_value({test_name, " load_data"}, data_q.pop_front(), load_data);
				void'(due_q.pop_front());
			end else if (load_valid) begin
				stop_with_error({"load_valid high with no load pending in ", test_name});
			end
			// Memory edge, reads see the old word
			wb_now = wb_cyc && wb_stb && !wb_ack;
			if (p_valid && !p_we) begin
				due_q.push_back(cycle_n + 2);
				data_q.push_back(extract_load(model_mem[p_addr[11:2]], p_op, p_addr[1:0]));
			end
			if (wb_now && !wb_we)
				ack_dat = model_mem[wb_adr];
			if (wb_now && wb_we) begin
				for (int i = 0; i < `LSU_BYTES; i++)
					if (wb_sel[i])
						model_mem[wb_adr][i*8 +: 8] = wb_dat_i[i*8 +: 8];
			end
			if (p_valid && p_we)	// After the bus write, core wins
				model_mem[p_addr[11:2]] = merge_store(model_mem[p_addr[11:2]], p_op,
					p_addr[1:0], p_wdata);
			ack_exp = wb_now;
			ack_we = wb_we;
			p_valid = req_valid;
			p_we = req_we;
			p_op = req_op;
			p_addr = req_addr;
			p_wdata = req_wdata;
		end
	end

	always @(posedge CLK) begin
		cycle_n <= cycle_n + 1;
		if (cycle_n == LIMIT)
			stop_with_error("Timeout, the run did not reach its end");
	end

	////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////
	initial begin
		logic [31:0] r;
		logic [11:0] a;
		logic [9:0] adr;
		rst_n = 1'b0;
		req_valid = 1'b0;
		req_we = 1'b0;
		req_op = lsu_pkg::MEM_W;
		req_addr = '0;
		req_wdata = '0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_sel = '0;
		wb_adr = '0;
		wb_dat_i = '0;
		r = $urandom(32'h407b_b2fc);
		repeat (3) @(posedge CLK);
		rst_n <= 1'b1;
		repeat (3) begin
			@(posedge CLK);
			check_value("reset load_valid", 32'd0, 32'(load_valid));
			check_value("reset wb_ack", 32'd0, 32'(wb_ack));
		end

		start_test("word round trip");
		for (int i = 0; i < N_FILL; i++) begin
			@(posedge CLK);
			set_core(1'b1, 1'b1, lsu_pkg::MEM_W, 12'(i * 4), $urandom);
		end
		for (int k = 0; k < N_RT; k++) begin
			@(posedge CLK);
			set_core(1'b1, 1'b0, lsu_pkg::MEM_W, rand_addr(N_FILL), '0);
		end

		start_test("byte and half");
		for (int k = 0; k < N_SUB; k++) begin
			a = rand_addr(WIN);
			r = $urandom;
			@(posedge CLK);
			set_core(1'b1, 1'b1, r[0] ? lsu_pkg::MEM_H : lsu_pkg::MEM_B, a, $urandom);
			@(posedge CLK);
			set_core(1'b1, 1'b0, rand_op(1'b0), {a[11:2], r[2:1]}, '0);	// Same word
		end

		start_test("back to back");
		for (int k = 0; k < N_B2B; k++) begin
			@(posedge CLK);
			random_core(WIN);
		end

		start_test("wishbone");
		for (int k = 0; k < N_WB; k++) begin
			r = $urandom;
			adr = 10'($urandom_range(WIN - 1, 0));
			if (r[0]) begin
				wb_access(1'b1, adr, r[7:4], $urandom);
				@(posedge CLK);
				set_core(1'b1, 1'b0, lsu_pkg::MEM_W, {adr, 2'b00}, '0);
			end else begin
				@(posedge CLK);
				set_core(1'b1, 1'b1, lsu_pkg::MEM_W, {adr, 2'b00}, $urandom);
				@(posedge CLK);
				set_core(1'b0, 1'b0, lsu_pkg::MEM_W, '0, '0);	// Store lands first
				wb_access(1'b0, adr, 4'hf, '0);
			end
		end

		start_test("drain");
		@(posedge CLK);
		set_core(1'b0, 1'b0, lsu_pkg::MEM_W, '0, '0);
		repeat (4) @(negedge CLK);		// Load latency is fixed at two
		if (due_q.size() == 0 && !ack_exp) begin
			$display("Done: no errors");
			$finish;
		end else begin
			stop_with_error("Loads or acks still outstanding at the end of the run");
		end
	end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+common
common/lsu_pkg.sv
common/lsu_req_if.sv
common/lsu_rsp_if.sv
verilog/store_align.sv
datamem/data_mem.sv
verilog/load_extract.sv
verilog/mem_stage_top.sv
bench/tb_mem_stage.sv

// ==== Makefile ====
# Verilator simulation of the memory stage
VERILATOR ?= verilator
TOP ?= tb_mem_stage
FLAGS ?= --binary --timing --assert --timescale 1ns/1ns
OBJ_DIR ?= obj_dir

.PHONY: sim clean

# Exit status of the binary carries pass or fail
sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f src.f
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
